//--- Makefile
# Verilator build and run for the memory subsystem testbench.

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= *** TEST PASSED ***

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed, log in $(LOG)."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
source/memctl_pkg.sv
source/region_decoder.sv
source/block_ram.sv
source/local_store.sv
source/cpu_mem_controller.sv
source/mem_subsystem.sv
bench/clock_gen.sv
bench/tb_mem_subsystem.sv

//--- bench/clock_gen.sv
module clock_gen (
   output logic clk,
   output logic rst
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int half_period  = 10;
   localparam int reset_cycles = 5;

   initial begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   // Reset is released just after an edge, in step with the stimulus.
   initial begin
      rst = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #2;
      rst = 1'b0;
   end

endmodule

//--- bench/tb_mem_subsystem.sv
module tb_mem_subsystem;
   timeunit 1ns;
   timeprecision 100ps;
   import memctl_pkg::*;

   localparam int drive_delay  = 2;   // Inputs change this long after the rising edge.
   localparam int ack_limit    = 20;
   localparam int hold_cycles  = 10;
   localparam int main_count   = 8;
   localparam int bios_count   = 4;
   localparam int hwreg_count  = 16;
   localparam int null_count   = 4;
   localparam int clk_period   = 20;
   localparam int reset_cycles = 5;
   localparam int access_count = 3 * main_count + 2 + 3 * bios_count + 2 +
                                 2 * scratch_words + 2 * hwreg_count + 2 * null_count + 8;
   localparam int watchdog_ns  = access_count * 10 * clk_period + reset_cycles * clk_period;

   logic      clk;
   logic      rst;
   cpu_addr_t addr;
   word_t     data_in;
   logic      ren;
   logic      wen;
   logic      ack;
   word_t     data_out;
   string     test_name;

   clock_gen i_clock (
      .clk (clk),
      .rst (rst)
   );

   mem_subsystem i_dut (
      .clk      (clk),
      .rst      (rst),
      .addr     (addr),
      .data_in  (data_in),
      .ren      (ren),
      .wen      (wen),
      .ack      (ack),
      .data_out (data_out)
   );

   task automatic abort_run();
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped at the first failure.");
   endtask

   task automatic check_word(input string what, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("** Error [%s] %s: expected %h, actual %h",
                  test_name, what, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_flag(input string what, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("** Error [%s] %s: expected %b, actual %b",
                  test_name, what, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_latency(input string what, input int expected, input int actual);
      if (actual != expected) begin
         $display("** Error [%s] %s: expected %0d cycles, actual %0d cycles",
                  test_name, what, expected, actual);
         abort_run();
      end
   endtask

   task automatic step();
      @(posedge clk);
      #drive_delay;
   endtask

   function automatic cpu_addr_t mirror_addr(input logic [2:0] tag, input logic [28:0] offset);
      cpu_addr_t a;
      a.seg.tag    = tag;
      a.seg.offset = offset;
      return a;
   endfunction

   // Samples spread over the window and end on the last register.
   function automatic int hwreg_sample(input int j);
      return (j == hwreg_count - 1) ? hwreg_words - 1 : j * 131;
   endfunction

   // One full four-phase cycle. Rise is counted from the edge that samples the request.
   task automatic run_access(input logic write, input cpu_addr_t a, input word_t wdata,
                             input int hold, output word_t rdata,
                             output int rise, output int fall);
      int n;
      addr    = a;
      data_in = wdata;
      ren     = !write;
      wen     = write;
      n       = 0;
      do begin
         step();
         n++;
      end while (!ack && n < ack_limit);
      if (!ack) begin
         $display("No ack from the DUT within %0d cycles for address %h.", ack_limit, a);
         abort_run();
      end
      rise  = n - 1;
      rdata = data_out;
      for (int i = 0; i < hold; i++) begin
         step();
         check_flag("ack while request held", 1'b1, ack);
         check_word("data_out while request held", rdata, data_out);
      end
      ren = 1'b0;
      wen = 1'b0;
      n   = 0;
      do begin
         step();
         n++;
      end while (ack && n < ack_limit);
      if (ack) begin
         $display("The DUT kept ack high after the request dropped, address %h.", a);
         abort_run();
      end
      fall = n;
   endtask

   task automatic cpu_write(input cpu_addr_t a, input word_t wdata);
      word_t unused_data;
      int    rise;
      int    fall;
      run_access(1'b1, a, wdata, 0, unused_data, rise, fall);
   endtask

   task automatic cpu_read(input cpu_addr_t a, output word_t rdata);
      int rise;
      int fall;
      run_access(1'b0, a, '0, 0, rdata, rise, fall);
   endtask

   task automatic test_reset();
      test_name = "reset";
      check_flag("ack after reset", 1'b0, ack);
      check_word("data_out after reset", '0, data_out);
   endtask

   task automatic test_main_mirrors();
      logic [28:0] offs [main_count];
      word_t       vals [main_count];
      word_t       d;
      test_name = "main_mirrors";
      for (int i = 0; i < main_count; i++) begin
         // One word per 256 KiB stripe, so the offsets never collide.
         offs[i] = 29'(i * 32'h0004_0000) | 29'($urandom() & 32'h0003_FFFC);
         vals[i] = $urandom();
         cpu_write(mirror_addr(kuseg_tag, offs[i]), vals[i]);
      end
      for (int i = 0; i < main_count; i++) begin
         cpu_read(mirror_addr(kseg0_tag, offs[i]), d);
         check_word("KSEG0 mirror read", vals[i], d);
         cpu_read(mirror_addr(kseg1_tag, offs[i]), d);
         check_word("KSEG1 mirror read", vals[i], d);
      end
      cpu_write(32'h0020_0000, $urandom());  // First byte past 2 MiB.
      cpu_read(32'h0020_0000, d);
      check_word("read past main memory", '0, d);
   endtask

   task automatic test_bios();
      word_t       vals [bios_count];
      word_t       probe_val;
      word_t       d;
      logic [28:0] off;
      test_name = "bios";
      // Same low address bits as the first BIOS word but a different RAM index.
      probe_val = $urandom();
      cpu_write(32'h0000_0100, probe_val);
      for (int i = 0; i < bios_count; i++) begin
         vals[i] = $urandom();
         off     = 29'(32'h1FC0_0100 + i * 32'h4000);
         cpu_write(mirror_addr(kseg1_tag, off), vals[i]);
      end
      for (int i = 0; i < bios_count; i++) begin
         off = 29'(32'h1FC0_0100 + i * 32'h4000);
         cpu_read(mirror_addr(kuseg_tag, off), d);
         check_word("KUSEG BIOS read", vals[i], d);
         cpu_read(mirror_addr(kseg0_tag, off), d);
         check_word("KSEG0 BIOS read", vals[i], d);
      end
      cpu_read(32'h0000_0100, d);
      check_word("main word beside BIOS", probe_val, d);
   endtask

   task automatic test_local_stores();
      word_t a;
      word_t d;
      test_name = "local_stores";
      for (int i = 0; i < scratch_words; i++) begin
         a = scratch_start + 32'(i * 4);
         cpu_write(a, ~a);
      end
      // The hardware-register pattern differs, so aliasing to the scratchpad shows up.
      for (int j = 0; j < hwreg_count; j++) begin
         a = hwreg_start + 32'(hwreg_sample(j) * 4);
         cpu_write(a, a ^ 32'hA5A5_A5A5);
      end
      for (int i = 0; i < scratch_words; i++) begin
         a = scratch_start + 32'(i * 4);
         cpu_read(a, d);
         check_word("scratchpad read", ~a, d);
      end
      for (int j = 0; j < hwreg_count; j++) begin
         a = hwreg_start + 32'(hwreg_sample(j) * 4);
         cpu_read(a, d);
         check_word("hardware register read", a ^ 32'hA5A5_A5A5, d);
      end
   endtask

   task automatic test_null_regions();
      word_t addrs [null_count];
      word_t d;
      test_name = "null_regions";
      addrs[0] = parport_start;
      addrs[1] = parport_end - 32'd4;
      addrs[2] = 32'h1F10_0000;  // Gap between the parallel port and the scratchpad.
      addrs[3] = 32'hC000_0000;  // KSEG2 has no mapping.
      for (int i = 0; i < null_count; i++) begin
         cpu_write(addrs[i], $urandom());
         cpu_read(addrs[i], d);
         check_word("read after discarded write", '0, d);
      end
   endtask

   task automatic test_handshake();
      word_t v;
      word_t d;
      int    rise;
      int    fall;
      test_name = "handshake";
      v = $urandom();
      run_access(1'b1, 32'h0000_0400, v, 0, d, rise, fall);
      check_latency("main write ack rise", 3, rise);
      check_latency("main write ack fall", 1, fall);
      run_access(1'b0, 32'h8000_0400, '0, hold_cycles, d, rise, fall);
      check_latency("main read ack rise", 3, rise);
      check_latency("main read ack fall", 1, fall);
      check_word("main read data", v, d);
      run_access(1'b0, 32'hBFC0_0100, '0, 0, d, rise, fall);
      check_latency("BIOS read ack rise", 3, rise);
      v = $urandom();
      run_access(1'b1, 32'h1F80_03FC, v, 0, d, rise, fall);
      check_latency("scratchpad write ack rise", 2, rise);
      run_access(1'b0, 32'h1F80_03FC, '0, hold_cycles, d, rise, fall);
      check_latency("scratchpad read ack rise", 2, rise);
      check_latency("scratchpad read ack fall", 1, fall);
      check_word("scratchpad read data", v, d);
      run_access(1'b0, 32'h1F80_2FFC, '0, 0, d, rise, fall);
      check_latency("hardware register read ack rise", 2, rise);
      run_access(1'b0, parport_start, '0, hold_cycles, d, rise, fall);
      check_latency("parallel port read ack rise", 2, rise);
      check_word("parallel port read data", '0, d);
      run_access(1'b1, 32'h1F10_0000, v, 0, d, rise, fall);
      check_latency("unmapped write ack rise", 2, rise);
   endtask

   initial begin
      addr    = '0;
      data_in = '0;
      ren     = 1'b0;
      wen     = 1'b0;
      void'($urandom(32'h8b1c));
      @(negedge rst);
      test_reset();
      test_main_mirrors();
      test_bios();
      test_local_stores();
      test_null_regions();
      test_handshake();
      $display("*** TEST PASSED ***");
      $finish;
   end

   initial begin
      #watchdog_ns;
      $display("Watchdog expired after %0d ns before the tests finished.", watchdog_ns);
      abort_run();
   end

endmodule

//--- source/block_ram.sv
module block_ram (
   input  logic                             clk,
   input  logic [memctl_pkg::ram_addr_w-1:0] addr,
   input  logic                             we,
   input  memctl_pkg::word_t                wdata,
   output memctl_pkg::word_t                rdata
);
   import memctl_pkg::*;

   word_t mem [ram_words];  // BIOS image and main memory.

   // Read-first single port. The read register gives one cycle of latency.
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
   end

endmodule

//--- source/cpu_mem_controller.sv
module cpu_mem_controller (
   input  logic                               clk,
   input  logic                               rst,
   input  memctl_pkg::cpu_addr_t              addr,
   input  memctl_pkg::word_t                  data_in,
   input  logic                               ren,
   input  logic                               wen,
   output logic                               ack,
   output memctl_pkg::word_t                  data_out,
   input  memctl_pkg::mem_region_e            region,
   input  logic [memctl_pkg::ram_addr_w-1:0]  ram_index,
   input  logic [memctl_pkg::hwreg_idx_w-1:0] local_index,
   output logic [memctl_pkg::ram_addr_w-1:0]  ram_addr,
   output logic                               ram_we,
   output memctl_pkg::word_t                  ram_wdata,
   input  memctl_pkg::word_t                  ram_rdata,
   output logic                               scratch_en,
   output logic                               hwreg_en,
   output logic                               local_we,
   output logic [memctl_pkg::hwreg_idx_w-1:0] local_index_q,
   output memctl_pkg::word_t                  local_wdata,
   input  memctl_pkg::word_t                  scratch_rdata,
   input  memctl_pkg::word_t                  hwreg_rdata
);
   import memctl_pkg::*;

   ctl_state_e            state;
   ctl_state_e            state_next;
   mem_region_e           region_q;
   logic                  read_q;
   logic [ram_addr_w-1:0] ram_index_q;
   word_t                 wdata_q;
   word_t                 ram_hold;
   word_t                 read_pick;
   logic                  req;
   logic                  local_access;

   assign req = ren || wen;

   always_comb begin
      state_next = state;
      case (state)
         st_idle: begin
            if (req) begin
               case (region)
                  region_bios, region_main: begin
                     state_next = ren ? st_ram_addr : st_ram_write;
                  end
                  region_scratch, region_hwreg: begin
                     state_next = ren ? st_local_read : st_local_write;
                  end
                  default: begin
                     state_next = st_null;  // Parallel port and unmapped space.
                  end
               endcase
            end
         end
         st_ram_addr:    state_next = st_ram_data;
         st_ram_data:    state_next = st_done;
         st_ram_write:   state_next = st_ram_commit;
         st_ram_commit:  state_next = st_done;
         st_local_read:  state_next = st_done;
         st_local_write: state_next = st_done;
         st_null:        state_next = st_done;
         st_done: begin
            if (!req) begin
               state_next = st_idle;  // CPU has finished with the data.
            end
         end
         default:        state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= st_idle;
         region_q <= region_none;
         read_q   <= 1'b0;
      end else begin
         state <= state_next;
         if (state == st_idle && req) begin
            region_q <= region;
            read_q   <= ren;
         end
      end
   end

   // Address and data are captured once, when the request is accepted.
   always_ff @(posedge clk) begin
      if (state == st_idle && req) begin
         ram_index_q   <= ram_index;
         local_index_q <= local_index;
         wdata_q       <= data_in;
      end
      if (state == st_ram_data) begin
         ram_hold <= ram_rdata;  // RAM output for the address shown in st_ram_addr.
      end
   end

   always_comb begin
      case (region_q)
         region_bios, region_main: read_pick = ram_hold;
         region_scratch:           read_pick = scratch_rdata;
         region_hwreg:             read_pick = hwreg_rdata;
         default:                  read_pick = '0;
      endcase
   end

   // Ack rises one edge after st_done is reached and holds until the request drops.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ack      <= 1'b0;
         data_out <= '0;
      end else if (state == st_done) begin
         if (!req) begin
            ack <= 1'b0;
         end else if (!ack) begin
            ack <= 1'b1;
            if (read_q) begin
               data_out <= read_pick;
            end
         end
      end
   end

   assign ram_addr    = ram_index_q;
   assign ram_wdata   = wdata_q;
   assign ram_we      = (state == st_ram_write);
   assign local_wdata = wdata_q;
   assign local_we    = (state == st_local_write);

   assign local_access = (state == st_local_read) || (state == st_local_write);
   assign scratch_en   = local_access && (region_q == region_scratch);
   assign hwreg_en     = local_access && (region_q == region_hwreg);

   a_one_request: assert property (
      @(posedge clk) disable iff (rst)
      !(ren && wen)
   ) else $error("ren and wen asserted together");

   a_no_ack_in_idle: assert property (
      @(posedge clk) disable iff (rst)
      (state == st_idle) |-> !ack
   ) else $error("ack high while the controller is idle");

   a_we_single: assert property (
      @(posedge clk) disable iff (rst)
      $rose(ram_we) |=> !ram_we
   ) else $error("ram_we held longer than one cycle");

   // The CPU must keep the address steady for the whole access.
   a_addr_held: assert property (
      @(posedge clk) disable iff (rst)
      (state != st_idle) && req |-> $stable(addr)
   ) else $error("addr changed during an access");

endmodule

//--- source/local_store.sv
module local_store #(
   parameter int depth = memctl_pkg::scratch_words
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              en,
   input  logic                              we,
   input  logic [memctl_pkg::hwreg_idx_w-1:0] index,
   input  memctl_pkg::word_t                 wdata,
   output memctl_pkg::word_t                 rdata
);
   import memctl_pkg::*;

   localparam int aw = $clog2(depth);

   word_t         mem [depth];
   logic [aw-1:0] slot;

   assign slot = index[aw-1:0];  // Upper bits are zero for in-range accesses.

   always_ff @(posedge clk) begin
      if (en && we) begin
         mem[slot] <= wdata;
      end
   end

   // A read updates rdata only when the store is enabled, so it holds otherwise.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rdata <= '0;
      end else if (en && !we) begin
         rdata <= mem[slot];
      end
   end

   // The decoder and controller together must never hand over an index past the end.
   a_index_in_range: assert property (
      @(posedge clk) disable iff (rst)
      en |-> (int'(index) < depth)
   ) else $error("local_store index %0d out of range for depth %0d", index, depth);

endmodule

//--- source/mem_subsystem.sv
module mem_subsystem (
   input  logic                  clk,
   input  logic                  rst,
   input  memctl_pkg::cpu_addr_t addr,
   input  memctl_pkg::word_t     data_in,
   input  logic                  ren,
   input  logic                  wen,
   output logic                  ack,
   output memctl_pkg::word_t     data_out
);
   import memctl_pkg::*;

   mem_region_e            region;
   logic [ram_addr_w-1:0]  ram_index;
   logic [ram_addr_w-1:0]  ram_addr;
   logic [hwreg_idx_w-1:0] local_index;
   logic [hwreg_idx_w-1:0] local_index_q;
   logic                   ram_we;
   word_t                  ram_wdata;
   word_t                  ram_rdata;
   logic                   scratch_en;
   logic                   hwreg_en;
   logic                   local_we;
   word_t                  local_wdata;
   word_t                  scratch_rdata;
   word_t                  hwreg_rdata;

   region_decoder i_decoder (
      .addr        (addr),
      .region      (region),
      .ram_index   (ram_index),
      .local_index (local_index)
   );

   cpu_mem_controller i_ctl (
      .clk           (clk),
      .rst           (rst),
      .addr          (addr),
      .data_in       (data_in),
      .ren           (ren),
      .wen           (wen),
      .ack           (ack),
      .data_out      (data_out),
      .region        (region),
      .ram_index     (ram_index),
      .local_index   (local_index),
      .ram_addr      (ram_addr),
      .ram_we        (ram_we),
      .ram_wdata     (ram_wdata),
      .ram_rdata     (ram_rdata),
      .scratch_en    (scratch_en),
      .hwreg_en      (hwreg_en),
      .local_we      (local_we),
      .local_index_q (local_index_q),
      .local_wdata   (local_wdata),
      .scratch_rdata (scratch_rdata),
      .hwreg_rdata   (hwreg_rdata)
   );

   block_ram i_ram (
      .clk   (clk),
      .addr  (ram_addr),
      .we    (ram_we),
      .wdata (ram_wdata),
      .rdata (ram_rdata)
   );

   local_store #(
      .depth (scratch_words)
   ) i_scratch (
      .clk   (clk),
      .rst   (rst),
      .en    (scratch_en),
      .we    (local_we),
      .index (local_index_q),
      .wdata (local_wdata),
      .rdata (scratch_rdata)
   );

   local_store #(
      .depth (hwreg_words)
   ) i_hwreg (
      .clk   (clk),
      .rst   (rst),
      .en    (hwreg_en),
      .we    (local_we),
      .index (local_index_q),
      .wdata (local_wdata),
      .rdata (hwreg_rdata)
   );

endmodule

//--- source/memctl_pkg.sv
package memctl_pkg;

   typedef logic [31:0] word_t;

   // Segment view: the top three bits select KUSEG, KSEG0 or KSEG1.
   typedef struct packed {
      logic [2:0]  tag;
      logic [28:0] offset;
   } addr_seg_t;

   // Word view: word address plus the byte lane inside the word.
   typedef struct packed {
      logic [29:0] word;
      logic [1:0]  lane;
   } addr_word_t;

   typedef union packed {
      addr_seg_t  seg;
      addr_word_t wrd;
   } cpu_addr_t;

   typedef enum logic [2:0] {
      region_bios,
      region_main,
      region_scratch,
      region_hwreg,
      region_parport,
      region_none
   } mem_region_e;

   typedef enum logic [3:0] {
      st_idle,
      st_ram_addr,
      st_ram_data,
      st_ram_write,
      st_ram_commit,
      st_local_read,
      st_local_write,
      st_null,
      st_done
   } ctl_state_e;

   localparam logic [2:0] kuseg_tag = 3'b000;
   localparam logic [2:0] kseg0_tag = 3'b100;
   localparam logic [2:0] kseg1_tag = 3'b101;

   localparam int ram_addr_w = 20;
   localparam int ram_words  = 1 << ram_addr_w;

   localparam logic [28:0]           main_mem_limit = 29'h020_0000; // 2 MiB.
   localparam logic [ram_addr_w-1:0] main_mem_base  = 20'h4_0000;   // Word index in the RAM.

   localparam logic [31:0] bios_start    = 32'h1FC0_0000;
   localparam logic [31:0] bios_end      = 32'h1FC8_0000;
   localparam logic [31:0] parport_start = 32'h1F00_0000;
   localparam logic [31:0] parport_end   = 32'h1F01_0000;
   localparam logic [31:0] scratch_start = 32'h1F80_0000;
   localparam logic [31:0] scratch_end   = 32'h1F80_0400;
   localparam logic [31:0] hwreg_start   = 32'h1F80_1000;
   localparam logic [31:0] hwreg_end     = 32'h1F80_3000;

   localparam int scratch_words = 256;
   localparam int scratch_idx_w = 8;
   localparam int hwreg_words   = 2048;
   localparam int hwreg_idx_w   = 11;  // Also the width of the shared local index.

endpackage

//--- source/region_decoder.sv
module region_decoder (
   input  memctl_pkg::cpu_addr_t                  addr,
   output memctl_pkg::mem_region_e                region,
   output logic [memctl_pkg::ram_addr_w-1:0]      ram_index,
   output logic [memctl_pkg::hwreg_idx_w-1:0]     local_index
);
   import memctl_pkg::*;

   logic                  seg_ok;
   logic [31:0]           phys_addr;
   logic                  in_bios;
   logic                  in_main;
   logic                  in_scratch;
   logic                  in_hwreg;
   logic                  in_parport;
   logic [ram_addr_w-1:0] bios_index;
   logic [ram_addr_w-1:0] main_index;
   logic [29:0]           hwreg_offset;

   // All three mirror segments map onto the same physical space.
   assign seg_ok = (addr.seg.tag == kuseg_tag) ||
                   (addr.seg.tag == kseg0_tag) ||
                   (addr.seg.tag == kseg1_tag);

   assign phys_addr = {3'b000, addr.seg.offset};

   assign in_bios = seg_ok && (phys_addr >= bios_start) && (phys_addr < bios_end);
   assign in_main = seg_ok && (addr.seg.offset < main_mem_limit);

   // The I/O windows are only seen at their KUSEG addresses.
   assign in_scratch = (addr.wrd.word >= scratch_start[31:2]) &&
                       (addr.wrd.word < scratch_end[31:2]);
   assign in_hwreg   = (addr.wrd.word >= hwreg_start[31:2]) &&
                       (addr.wrd.word < hwreg_end[31:2]);
   assign in_parport = (addr.wrd.word >= parport_start[31:2]) &&
                       (addr.wrd.word < parport_end[31:2]);

   always_comb begin
      region = region_none;
      if (in_bios) begin
         region = region_bios;
      end else if (in_main) begin
         region = region_main;
      end else if (in_scratch) begin
         region = region_scratch;
      end else if (in_hwreg) begin
         region = region_hwreg;
      end else if (in_parport) begin
         region = region_parport;
      end
   end

   // BIOS sits at the bottom of the RAM, main memory above it.
   assign bios_index = ram_addr_w'(addr.wrd.word[16:0]);
   assign main_index = ram_addr_w'(addr.wrd.word[18:0]) + main_mem_base;
   assign ram_index  = in_bios ? bios_index : main_index;

   assign hwreg_offset = addr.wrd.word - hwreg_start[31:2];

   // One index serves both stores; only the enabled store looks at it.
   assign local_index = in_scratch ? hwreg_idx_w'(addr.wrd.word[scratch_idx_w-1:0])
                                   : hwreg_offset[hwreg_idx_w-1:0];

endmodule
